// ==== logic/l2c_defines.svh ====
/*
  Widths and depths of the level-2 cache response pipeline.
  The rfifo depth must stay at 3 or less, since its pointers are 2 bits wide.
*/
`ifndef L2C_DEFINES_SVH
`define L2C_DEFINES_SVH

// Line and array geometry
`define L2C_DATA_WIDTH   64
`define L2C_INDEX_WIDTH  4

// Completion fields toward the CIU
`define L2C_SID_WIDTH    5
`define L2C_CP_WIDTH     4
`define L2C_RESP_WIDTH   5

// Response FIFO entries
`define L2C_RFIFO_DEPTH  3

`endif

// ==== logic/l2c_pkg.sv ====
/*
  Shared types of the response pipeline.
  Only two resp codes are defined, and the other resp values are unused.
*/
`default_nettype none

`include "l2c_defines.svh"

package l2c_pkg;

  // Vector types sized from the defines header
  typedef logic [`L2C_DATA_WIDTH-1:0]  l2c_data_t;
  typedef logic [`L2C_INDEX_WIDTH-1:0] l2c_index_t;
  typedef logic [`L2C_SID_WIDTH-1:0]   l2c_sid_t;
  typedef logic [`L2C_CP_WIDTH-1:0]    l2c_cp_t;
  typedef logic [`L2C_RESP_WIDTH-1:0]  l2c_resp_t;

  // Request kind
  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } l2c_op_e;

  // Completion codes
  localparam l2c_resp_t resp_read_data  = 5'b00001;
  localparam l2c_resp_t resp_write_done = 5'b00100;

endpackage

`default_nettype wire

// ==== logic/l2c_tag_stage.sv ====
/*
  Ack side of the four-phase request handshake.
  A request is taken only while the rfifo has two or more free slots.
*/
`timescale 1ns/1ps
`default_nettype none

module l2c_tag_stage
  import l2c_pkg::*;
(
  input  wire        l2c_clk,
  input  wire        cpurst_b,
  input  wire        req_vld,
  input  l2c_op_e    req_op,
  input  l2c_index_t req_index,
  input  l2c_data_t  req_wdata,
  input  l2c_sid_t   req_sid,
  input  l2c_cp_t    req_cp,
  input  wire        rfifo_afull,
  output logic       req_ack,
  output logic       tag_vld,
  output l2c_op_e    tag_op,
  output l2c_index_t tag_index,
  output l2c_data_t  tag_wdata,
  output l2c_sid_t   tag_sid,
  output l2c_cp_t    tag_cp
);

  logic accept;

  // New request seen, previous ack gone, stage free, room downstream
  assign accept = req_vld && !req_ack && !tag_vld && !rfifo_afull;

  // Ack rises on accept and falls once the requester has let go
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      req_ack <= 1'b0;
      tag_vld <= 1'b0;
    end
    else
    begin
      tag_vld <= accept;
      if (accept)
        req_ack <= 1'b1;
      else if (req_ack && !req_vld)
        req_ack <= 1'b0;
    end
  end

  // Request fields held for the one stage cycle
  always_ff @(posedge l2c_clk)
  begin
    if (accept)
    begin
      tag_op    <= req_op;
      tag_index <= req_index;
      tag_wdata <= req_wdata;
      tag_sid   <= req_sid;
      tag_cp    <= req_cp;
    end
  end

endmodule

`default_nettype wire

// ==== logic/l2c_cmp_stage.sv ====
/*
  Compare stage. Every access hits, so the stage only splits by op.
  Writes end here, and only reads go on to the data stage.
*/
`timescale 1ns/1ps
`default_nettype none

module l2c_cmp_stage
  import l2c_pkg::*;
(
  input  wire        l2c_clk,
  input  wire        cpurst_b,
  input  wire        tag_vld,
  input  l2c_op_e    tag_op,
  input  l2c_index_t tag_index,
  input  l2c_data_t  tag_wdata,
  input  l2c_sid_t   tag_sid,
  input  l2c_cp_t    tag_cp,
  output logic       cmp_vld,
  output l2c_index_t cmp_index,
  output l2c_sid_t   cmp_sid,
  output l2c_cp_t    cmp_cp,
  output logic       arr_wen,
  output l2c_index_t arr_windex,
  output l2c_data_t  arr_wdata,
  output logic       rfifo_create,
  output l2c_sid_t   rfifo_create_sid,
  output l2c_cp_t    rfifo_create_cp,
  output l2c_resp_t  rfifo_create_resp
);

  l2c_data_t cmp_wdata;
  logic      cmp_wr_vld;

  // Stage valids split by op
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cmp_vld    <= 1'b0;
      cmp_wr_vld <= 1'b0;
    end
    else
    begin
      cmp_vld    <= tag_vld && (tag_op == op_read);
      cmp_wr_vld <= tag_vld && (tag_op == op_write);
    end
  end

  always_ff @(posedge l2c_clk)
  begin
    if (tag_vld)
    begin
      cmp_index <= tag_index;
      cmp_wdata <= tag_wdata;
      cmp_sid   <= tag_sid;
      cmp_cp    <= tag_cp;
    end
  end

  // ==============================
  // Write retire
  // ==============================
  // Array write and rfifo push land on the edge that ends this cycle
  assign arr_wen           = cmp_wr_vld;
  assign arr_windex        = cmp_index;
  assign arr_wdata         = cmp_wdata;
  assign rfifo_create      = cmp_wr_vld;
  assign rfifo_create_sid  = cmp_sid;
  assign rfifo_create_cp   = cmp_cp;
  assign rfifo_create_resp = resp_write_done;

endmodule

`default_nettype wire

// ==== logic/l2c_data_stage.sv ====
/*
  Data array of 16 lines with a registered read port.
  A read returns the line as it was before a write on the same edge.
*/
`timescale 1ns/1ps
`default_nettype none

module l2c_data_stage
  import l2c_pkg::*;
(
  input  wire        l2c_clk,
  input  wire        cpurst_b,
  input  wire        cmp_vld,
  input  l2c_index_t cmp_index,
  input  l2c_sid_t   cmp_sid,
  input  l2c_cp_t    cmp_cp,
  input  wire        arr_wen,
  input  l2c_index_t arr_windex,
  input  l2c_data_t  arr_wdata,
  output logic       data_vld,
  output l2c_sid_t   data_sid,
  output l2c_cp_t    data_cp,
  output l2c_data_t  data_dout
);

  localparam int unsigned num_lines = 1 << $bits(l2c_index_t);

  l2c_data_t data_array [num_lines];

  // ==============================
  // Array
  // ==============================
  // Lines start out zero after reset
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      for (int i = 0; i < num_lines; i++)
        data_array[i] <= '0;
    end
    else if (arr_wen)
      data_array[arr_windex] <= arr_wdata;
  end

  // Stage valid
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      data_vld <= 1'b0;
    else
      data_vld <= cmp_vld;
  end

  // Read flop, old contents on a same-edge write
  always_ff @(posedge l2c_clk)
  begin
    if (cmp_vld)
    begin
      data_dout <= data_array[cmp_index];
      data_sid  <= cmp_sid;
      data_cp   <= cmp_cp;
    end
  end

endmodule

`default_nettype wire

// ==== logic/l2c_resp_fifo.sv ====
/*
  Response FIFO for data-less completions, head entry shown at the pop side.
  Pointers are 2 bits, so the depth from the defines header must not exceed 3.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l2c_defines.svh"

module l2c_resp_fifo
  import l2c_pkg::*;
(
  input  wire       l2c_clk,
  input  wire       cpurst_b,
  input  wire       create_en,
  input  l2c_sid_t  create_sid,
  input  l2c_cp_t   create_cp,
  input  l2c_resp_t create_resp,
  input  wire       pop_en,
  output logic      pop_vld,
  output l2c_sid_t  pop_sid,
  output l2c_cp_t   pop_cp,
  output l2c_resp_t pop_resp,
  output logic      empty,
  output logic      afull
);

  localparam logic [1:0] last_ptr = 2'(`L2C_RFIFO_DEPTH - 1);
  localparam logic [1:0] full_cnt = 2'(`L2C_RFIFO_DEPTH);

  l2c_sid_t   entry_sid  [`L2C_RFIFO_DEPTH];
  l2c_cp_t    entry_cp   [`L2C_RFIFO_DEPTH];
  l2c_resp_t  entry_resp [`L2C_RFIFO_DEPTH];
  logic [1:0] wptr;
  logic [1:0] rptr;
  logic [1:0] count;
  logic       full;

  // ==============================
  // Pointers and count
  // ==============================
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wptr  <= 2'd0;
      rptr  <= 2'd0;
      count <= 2'd0;
    end
    else
    begin
      if (create_en)
        wptr <= (wptr == last_ptr) ? 2'd0 : wptr + 2'd1;
      if (pop_en)
        rptr <= (rptr == last_ptr) ? 2'd0 : rptr + 2'd1;
      // Net change in occupancy
      case ({create_en, pop_en})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge l2c_clk)
  begin
    if (create_en)
    begin
      entry_sid[wptr]  <= create_sid;
      entry_cp[wptr]   <= create_cp;
      entry_resp[wptr] <= create_resp;
    end
  end

  // Status, afull with one slot or fewer left
  assign empty = (count == 2'd0);
  assign full  = (count == full_cnt);
  assign afull = (count >= last_ptr);

  // Head entry
  assign pop_vld  = !empty;
  assign pop_sid  = entry_sid[rptr];
  assign pop_cp   = entry_cp[rptr];
  assign pop_resp = entry_resp[rptr];

  // Ingress throttle must keep a slot for every write in flight
  a_no_overflow: assert property (@(posedge l2c_clk) disable iff (!cpurst_b)
    create_en |-> !full);

  // Arbiter only grants a real head entry
  a_no_underflow: assert property (@(posedge l2c_clk) disable iff (!cpurst_b)
    pop_en |-> !empty);

endmodule

`default_nettype wire

// ==== logic/l2c_wb.sv ====
/*
  Write-back stage and completion arbiter toward the CIU.
  The wb stage always wins, and the rfifo head goes out only in idle wb cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module l2c_wb
  import l2c_pkg::*;
(
  input  wire       l2c_clk,
  input  wire       cpurst_b,
  input  wire       data_vld,
  input  l2c_sid_t  data_sid,
  input  l2c_cp_t   data_cp,
  input  l2c_data_t data_dout,
  input  wire       rfifo_pop_vld,
  input  l2c_sid_t  rfifo_pop_sid,
  input  l2c_cp_t   rfifo_pop_cp,
  input  l2c_resp_t rfifo_pop_resp,
  output logic      wb_vld,
  output logic      rfifo_pop_en,
  output logic      cmplt,
  output l2c_sid_t  cmplt_sid,
  output l2c_cp_t   cmplt_cp,
  output l2c_resp_t cmplt_resp,
  output l2c_data_t cmplt_data
);

  l2c_sid_t  wb_sid;
  l2c_cp_t   wb_cp;
  l2c_data_t wb_data;

  // ==============================
  // Wb stage
  // ==============================
  always_ff @(posedge l2c_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_vld <= 1'b0;
    else
      wb_vld <= data_vld;
  end

  always_ff @(posedge l2c_clk)
  begin
    if (data_vld)
    begin
      wb_sid  <= data_sid;
      wb_cp   <= data_cp;
      wb_data <= data_dout;
    end
  end

  // ==============================
  // CIU completion
  // ==============================
  // Rfifo pops only into an empty wb slot
  assign rfifo_pop_en = !wb_vld && rfifo_pop_vld;

  // No back-pressure from the CIU
  assign cmplt      = wb_vld || rfifo_pop_en;
  assign cmplt_sid  = wb_vld ? wb_sid : rfifo_pop_sid;
  assign cmplt_cp   = wb_vld ? wb_cp : rfifo_pop_cp;
  assign cmplt_resp = wb_vld ? resp_read_data : rfifo_pop_resp;
  // Data bus only matters for read completions
  assign cmplt_data = wb_data;

endmodule

`default_nettype wire

// ==== logic/l2c_resp_top.sv ====
/*
  Response end of the level-2 cache pipeline, single clock domain.
  Every access hits its index, and the CIU accepts every completion.
*/
`timescale 1ns/1ps
`default_nettype none

module l2c_resp_top
  import l2c_pkg::*;
(
  input  wire        l2c_clk,
  input  wire        cpurst_b,
  input  wire        req_vld,
  input  l2c_op_e    req_op,
  input  l2c_index_t req_index,
  input  l2c_data_t  req_wdata,
  input  l2c_sid_t   req_sid,
  input  l2c_cp_t    req_cp,
  output logic       req_ack,
  output logic       cmplt,
  output l2c_sid_t   cmplt_sid,
  output l2c_cp_t    cmplt_cp,
  output l2c_resp_t  cmplt_resp,
  output l2c_data_t  cmplt_data,
  output logic       pipeline_rdy
);

  // Tag stage
  logic       tag_vld;
  l2c_op_e    tag_op;
  l2c_index_t tag_index;
  l2c_data_t  tag_wdata;
  l2c_sid_t   tag_sid;
  l2c_cp_t    tag_cp;
  // Compare stage
  logic       cmp_vld;
  l2c_index_t cmp_index;
  l2c_sid_t   cmp_sid;
  l2c_cp_t    cmp_cp;
  logic       arr_wen;
  l2c_index_t arr_windex;
  l2c_data_t  arr_wdata;
  // Data stage
  logic       data_vld;
  l2c_sid_t   data_sid;
  l2c_cp_t    data_cp;
  l2c_data_t  data_dout;
  // Rfifo and wb
  logic       rfifo_create;
  l2c_sid_t   rfifo_create_sid;
  l2c_cp_t    rfifo_create_cp;
  l2c_resp_t  rfifo_create_resp;
  logic       rfifo_pop_en;
  logic       rfifo_pop_vld;
  l2c_sid_t   rfifo_pop_sid;
  l2c_cp_t    rfifo_pop_cp;
  l2c_resp_t  rfifo_pop_resp;
  logic       rfifo_empty;
  logic       rfifo_afull;
  logic       wb_vld;

  l2c_tag_stage x_tag_stage (
    .l2c_clk     (l2c_clk),
    .cpurst_b    (cpurst_b),
    .req_vld     (req_vld),
    .req_op      (req_op),
    .req_index   (req_index),
    .req_wdata   (req_wdata),
    .req_sid     (req_sid),
    .req_cp      (req_cp),
    .rfifo_afull (rfifo_afull),
    .req_ack     (req_ack),
    .tag_vld     (tag_vld),
    .tag_op      (tag_op),
    .tag_index   (tag_index),
    .tag_wdata   (tag_wdata),
    .tag_sid     (tag_sid),
    .tag_cp      (tag_cp)
  );

  l2c_cmp_stage x_cmp_stage (
    .l2c_clk           (l2c_clk),
    .cpurst_b          (cpurst_b),
    .tag_vld           (tag_vld),
    .tag_op            (tag_op),
    .tag_index         (tag_index),
    .tag_wdata         (tag_wdata),
    .tag_sid           (tag_sid),
    .tag_cp            (tag_cp),
    .cmp_vld           (cmp_vld),
    .cmp_index         (cmp_index),
    .cmp_sid           (cmp_sid),
    .cmp_cp            (cmp_cp),
    .arr_wen           (arr_wen),
    .arr_windex        (arr_windex),
    .arr_wdata         (arr_wdata),
    .rfifo_create      (rfifo_create),
    .rfifo_create_sid  (rfifo_create_sid),
    .rfifo_create_cp   (rfifo_create_cp),
    .rfifo_create_resp (rfifo_create_resp)
  );

  l2c_data_stage x_data_stage (
    .l2c_clk    (l2c_clk),
    .cpurst_b   (cpurst_b),
    .cmp_vld    (cmp_vld),
    .cmp_index  (cmp_index),
    .cmp_sid    (cmp_sid),
    .cmp_cp     (cmp_cp),
    .arr_wen    (arr_wen),
    .arr_windex (arr_windex),
    .arr_wdata  (arr_wdata),
    .data_vld   (data_vld),
    .data_sid   (data_sid),
    .data_cp    (data_cp),
    .data_dout  (data_dout)
  );

  l2c_resp_fifo x_resp_fifo (
    .l2c_clk     (l2c_clk),
    .cpurst_b    (cpurst_b),
    .create_en   (rfifo_create),
    .create_sid  (rfifo_create_sid),
    .create_cp   (rfifo_create_cp),
    .create_resp (rfifo_create_resp),
    .pop_en      (rfifo_pop_en),
    .pop_vld     (rfifo_pop_vld),
    .pop_sid     (rfifo_pop_sid),
    .pop_cp      (rfifo_pop_cp),
    .pop_resp    (rfifo_pop_resp),
    .empty       (rfifo_empty),
    .afull       (rfifo_afull)
  );

  l2c_wb x_wb (
    .l2c_clk        (l2c_clk),
    .cpurst_b       (cpurst_b),
    .data_vld       (data_vld),
    .data_sid       (data_sid),
    .data_cp        (data_cp),
    .data_dout      (data_dout),
    .rfifo_pop_vld  (rfifo_pop_vld),
    .rfifo_pop_sid  (rfifo_pop_sid),
    .rfifo_pop_cp   (rfifo_pop_cp),
    .rfifo_pop_resp (rfifo_pop_resp),
    .wb_vld         (wb_vld),
    .rfifo_pop_en   (rfifo_pop_en),
    .cmplt          (cmplt),
    .cmplt_sid      (cmplt_sid),
    .cmplt_cp       (cmplt_cp),
    .cmplt_resp     (cmplt_resp),
    .cmplt_data     (cmplt_data)
  );

  // Idle when no stage holds work, a write in compare counts as busy
  assign pipeline_rdy = !tag_vld && !cmp_vld && !arr_wen && !data_vld && !wb_vld
                        && rfifo_empty;

endmodule

`default_nettype wire

// ==== sim/l2c_resp_tb.sv ====
/*
  Random read/write traffic into the response pipeline, checked against a memory model.
  Requests are serialized by the four-phase handshake, so acceptance order is issue order.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l2c_defines.svh"

module l2c_resp_tb
  import l2c_pkg::*;
();

  localparam int clk_period      = 100;
  localparam int num_lines       = 1 << `L2C_INDEX_WIDTH;
  localparam int num_sids        = 1 << `L2C_SID_WIDTH;
  localparam int num_rand        = 200;
  localparam int num_burst       = 60;
  localparam int watchdog_cycles = (num_rand + num_burst) * 20 + 2000;

  logic       l2c_clk;
  logic       cpurst_b;
  logic       req_vld;
  l2c_op_e    req_op;
  l2c_index_t req_index;
  l2c_data_t  req_wdata;
  l2c_sid_t   req_sid;
  l2c_cp_t    req_cp;
  logic       req_ack;
  logic       cmplt;
  l2c_sid_t   cmplt_sid;
  l2c_cp_t    cmplt_cp;
  l2c_resp_t  cmplt_resp;
  l2c_data_t  cmplt_data;
  logic       pipeline_rdy;

  // ==============================
  // Model state
  // ==============================
  l2c_data_t  model_mem [num_lines];
  // Expected completion per sid
  logic       pend      [num_sids];
  l2c_cp_t    exp_cp    [num_sids];
  l2c_resp_t  exp_resp  [num_sids];
  l2c_data_t  exp_data  [num_sids];
  int         ack_cyc   [num_sids];
  int         cyc;
  int         err_cnt;
  int         cmplt_cnt;
  int         max_wait;
  int         errs_before;
  int         drain_cnt;

  l2c_resp_top uut (
    .l2c_clk      (l2c_clk),
    .cpurst_b     (cpurst_b),
    .req_vld      (req_vld),
    .req_op       (req_op),
    .req_index    (req_index),
    .req_wdata    (req_wdata),
    .req_sid      (req_sid),
    .req_cp       (req_cp),
    .req_ack      (req_ack),
    .cmplt        (cmplt),
    .cmplt_sid    (cmplt_sid),
    .cmplt_cp     (cmplt_cp),
    .cmplt_resp   (cmplt_resp),
    .cmplt_data   (cmplt_data),
    .pipeline_rdy (pipeline_rdy)
  );

  always #(clk_period / 2) l2c_clk = ~l2c_clk;

  // Edge count read at falling edges only
  always @(posedge l2c_clk)
    cyc <= cyc + 1;

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < num_sids; i++)
      if (pend[i])
        n++;
    return n;
  endfunction

  // Four-phase requester entered and left on a falling edge
  task automatic issue_request(input l2c_op_e op);
    l2c_sid_t   sid;
    l2c_index_t idx;
    l2c_data_t  wdata;
    int         t0;
    sid = l2c_sid_t'($urandom);
    while (pend[sid])
      sid = l2c_sid_t'($urandom);
    idx   = l2c_index_t'($urandom);
    wdata = {$urandom, $urandom};
    exp_cp[sid] = l2c_cp_t'($urandom);
    // Model moves in acceptance order
    if (op == op_write)
    begin
      exp_resp[sid]  = resp_write_done;
      model_mem[idx] = wdata;
    end
    else
    begin
      exp_resp[sid] = resp_read_data;
      exp_data[sid] = model_mem[idx];
    end
    pend[sid] = 1'b1;
    req_vld   = 1'b1;
    req_op    = op;
    req_index = idx;
    req_wdata = wdata;
    req_sid   = sid;
    req_cp    = exp_cp[sid];
    t0 = cyc;
    @(negedge l2c_clk);
    while (!req_ack)
      @(negedge l2c_clk);
    ack_cyc[sid] = cyc;
    if (cyc - t0 > max_wait)
      max_wait = cyc - t0;
    req_vld = 1'b0;
    @(negedge l2c_clk);
    while (req_ack)
      @(negedge l2c_clk);
  endtask

  // Wait for every outstanding sid and then expect an idle pipeline
  task automatic drain_and_check();
    drain_cnt = 0;
    while (pending_count() != 0 && drain_cnt < 200)
    begin
      @(negedge l2c_clk);
      drain_cnt++;
    end
    assert (pending_count() == 0)
    else
    begin
      $display("Completions missing: %0d sids never completed", pending_count());
      err_cnt++;
    end
    @(negedge l2c_clk);
    assert (pipeline_rdy)
    else
    begin
      $display("error: %0t ns pipeline_rdy low after all completions", $time);
      err_cnt++;
    end
  endtask

  // ==============================
  // Completion monitor
  // ==============================
  always @(negedge l2c_clk)
  begin
    if (cpurst_b && cmplt)
    begin
      // A completion needs the wb stage or an rfifo entry
      assert (!pipeline_rdy)
      else
      begin
        $display("error: %0t ns pipeline_rdy high during a completion", $time);
        err_cnt++;
      end
      assert (pend[cmplt_sid])
      else
      begin
        $display("error: %0t ns completion for sid %0d not outstanding", $time, cmplt_sid);
        err_cnt++;
      end
      if (pend[cmplt_sid])
      begin
        assert (cmplt_cp == exp_cp[cmplt_sid] && cmplt_resp == exp_resp[cmplt_sid])
        else
        begin
          $display("error: %0t ns sid %0d cp/resp %h/%h, expected %h/%h", $time, cmplt_sid,
                   cmplt_cp, cmplt_resp, exp_cp[cmplt_sid], exp_resp[cmplt_sid]);
          err_cnt++;
        end
        // Reads carry data and fixed latency
        if (exp_resp[cmplt_sid] == resp_read_data)
        begin
          assert (cmplt_data == exp_data[cmplt_sid])
          else
          begin
            $display("error: %0t ns sid %0d data %h, expected %h", $time, cmplt_sid,
                     cmplt_data, exp_data[cmplt_sid]);
            err_cnt++;
          end
          assert (cyc == ack_cyc[cmplt_sid] + 3)
          else
          begin
            $display("error: %0t ns sid %0d read latency %0d cycles, expected 3", $time,
                     cmplt_sid, cyc - ack_cyc[cmplt_sid]);
            err_cnt++;
          end
        end
        pend[cmplt_sid] = 1'b0;
        cmplt_cnt++;
      end
    end
  end

  // Watchdog
  initial
  begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("Some tests failed");
    $finish;
  end

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    void'($urandom(40373));
    l2c_clk   = 1'b0;
    cpurst_b  = 1'b0;
    req_vld   = 1'b0;
    req_op    = op_read;
    req_index = '0;
    req_wdata = '0;
    req_sid   = '0;
    req_cp    = '0;
    cyc       = 0;
    err_cnt   = 0;
    cmplt_cnt = 0;
    max_wait  = 0;
    for (int i = 0; i < num_lines; i++)
      model_mem[i] = '0;
    for (int i = 0; i < num_sids; i++)
      pend[i] = 1'b0;
    repeat (10) @(negedge l2c_clk);
    cpurst_b = 1'b1;
    @(negedge l2c_clk);

    // Idle state out of reset
    assert (!req_ack && !cmplt && pipeline_rdy)
    else
    begin
      $display("error: %0t ns after reset ack=%b cmplt=%b rdy=%b", $time, req_ack, cmplt,
               pipeline_rdy);
      err_cnt++;
    end
    $display("test reset_state: done, errors %0d", err_cnt);

    // Mixed traffic with idle gaps
    errs_before = err_cnt;
    for (int n = 0; n < num_rand; n++)
    begin
      issue_request(($urandom % 2) ? op_write : op_read);
      repeat ($urandom % 3) @(negedge l2c_clk);
    end
    drain_and_check();
    $display("test random_traffic: done, errors %0d", err_cnt - errs_before);

    // Write-heavy burst with no gaps
    errs_before = err_cnt;
    max_wait = 0;
    for (int n = 0; n < num_burst; n++)
      issue_request(($urandom % 4 != 0) ? op_write : op_read);
    drain_and_check();
    $display("test write_burst: done, errors %0d, longest ack wait %0d cycles",
             err_cnt - errs_before, max_wait);

    $display("tests 3, requests %0d, completions %0d, errors %0d", num_rand + num_burst,
             cmplt_cnt, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/l2c_pkg.sv
logic/l2c_tag_stage.sv
logic/l2c_cmp_stage.sv
logic/l2c_data_stage.sv
logic/l2c_resp_fifo.sv
logic/l2c_wb.sv
logic/l2c_resp_top.sv
sim/l2c_resp_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run, pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module l2c_resp_tb -o l2c_resp_sim &&
./obj_dir/l2c_resp_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "run.sh: PASS" ||
{
  echo "run.sh: FAIL"
  exit 1
}
